// ==== filelist.f ====
batrider_pkg.sv
bus_decoder.sv
ram_bank.sv
io_ports.sv
read_return.sv
batrider_bus.sv
tb_batrider_bus.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_batrider_bus
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_batrider_bus.sv ====
// batrider main bus testbench
`timescale 1ns/10ps

module tb_batrider_bus;

    localparam int RAM_LOOPS  = 16;
    localparam int MAX_CYCLES = 4000;  // the tests take about 800 cycles

    logic                    CLK96 = 1'b0;
    logic                    RESET96;
    batrider_pkg::bus_req_t  req;
    batrider_pkg::bus_rsp_t  rsp;
    batrider_pkg::cab_in_t   cab;
    batrider_pkg::video_in_t vid;
    logic [7:0]              latch3;
    logic [7:0]              latch4;
    logic                    gcu_ack = 1'b0;
    logic [15:0]             gcu_rdata;
    logic [7:0]              sndlatch;
    logic [7:0]              sndlatch2;
    batrider_pkg::gcu_op_t   gcu_op;
    logic [2:0]              objbank_slot;

    integer                seed = 76977;
    int                    error_count = 0;
    int                    tests_run = 0;
    int                    errs_at_start = 0;
    int                    cycle_count = 0;
    int                    vcnt = 0;       // cycles with valid sampled high
    int                    gcu_cnt = 0;
    int                    gcu_delay = 1;  // GCU answer time for the next command
    logic [15:0]           ref_mem [2][16384];  // 0 video RAM, 1 work RAM
    logic [15:0]           exp_rdata = '0;
    logic                  chk_rdata = 1'b0;
    logic                  gcu_acc = 1'b0;  // access ends on the GCU handshake
    batrider_pkg::gcu_op_t exp_op = batrider_pkg::GCU_NONE;
    logic [7:0]            exp_snd = '0;
    logic [7:0]            exp_snd2 = '0;
    logic [2:0]            exp_slot = '0;

    batrider_bus dut0 (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .req          (req),
        .rsp          (rsp),
        .cab          (cab),
        .vid          (vid),
        .latch3       (latch3),
        .latch4       (latch4),
        .gcu_ack      (gcu_ack),
        .gcu_rdata    (gcu_rdata),
        .sndlatch     (sndlatch),
        .sndlatch2    (sndlatch2),
        .gcu_op       (gcu_op),
        .objbank_slot (objbank_slot)
    );

    always #20 CLK96 = ~CLK96;

    always @(posedge CLK96) vcnt <= req.valid ? vcnt + 1 : 0;

    // GCU model with a one cycle ack pulse after gcu_delay cycles
    always @(posedge CLK96) begin
        if (RESET96) begin
            gcu_ack <= 1'b0;
            gcu_cnt <= 0;
        end else if (gcu_ack) begin
            gcu_ack <= 1'b0;
        end else if (gcu_op != batrider_pkg::GCU_NONE) begin
            if (gcu_cnt + 1 >= gcu_delay) begin
                gcu_ack <= 1'b1;
                gcu_cnt <= 0;
            end else begin
                gcu_cnt <= gcu_cnt + 1;
            end
        end
    end

    always @(posedge CLK96) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic count_error(input string msg);
        error_count = error_count + 1;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    a_fixed_ack: assert property (@(posedge CLK96) disable iff (RESET96)
        rsp.ack && !gcu_acc |-> vcnt == 3) else count_error("ack not 2 cycles after valid");
    a_ack_missing: assert property (@(posedge CLK96) disable iff (RESET96)
        req.valid && !gcu_acc && vcnt == 3 |-> rsp.ack) else count_error("ack missing");
    a_rdata: assert property (@(posedge CLK96) disable iff (RESET96)
        rsp.ack && chk_rdata |-> rsp.rdata == exp_rdata)
        else count_error($sformatf("read data %h, expected %h",
                                   $sampled(rsp.rdata), $sampled(exp_rdata)));
    a_gcu_ack: assert property (@(posedge CLK96) disable iff (RESET96)
        $past(gcu_ack && gcu_op != batrider_pkg::GCU_NONE, 2) |-> rsp.ack)
        else count_error("no bus ack one cycle after gcu_ack");
    a_gcu_early: assert property (@(posedge CLK96) disable iff (RESET96)
        rsp.ack && gcu_acc |-> $past(gcu_ack, 2)) else count_error("GCU access acked early");
    a_gcu_op: assert property (@(posedge CLK96) disable iff (RESET96)
        gcu_op != batrider_pkg::GCU_NONE |-> gcu_acc && gcu_op == exp_op)
        else count_error($sformatf("gcu_op %0d, expected %0d", $sampled(gcu_op),
                                   $sampled(exp_op)));
    a_gcu_hold: assert property (@(posedge CLK96) disable iff (RESET96)
        gcu_op != batrider_pkg::GCU_NONE && !gcu_ack |=> gcu_op == $past(gcu_op))
        else count_error("gcu_op dropped before gcu_ack");
    a_outputs: assert property (@(posedge CLK96) disable iff (RESET96)
        !req.valid |-> sndlatch == exp_snd && sndlatch2 == exp_snd2 && objbank_slot == exp_slot)
        else count_error($sformatf("latches %h %h slot %0d, expected %h %h %0d",
                                   $sampled(sndlatch), $sampled(sndlatch2),
                                   $sampled(objbank_slot), exp_snd, exp_snd2, exp_slot));

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    // active high player byte with direction bits 0..3 reversed
    function automatic logic [7:0] player_byte(input logic [9:0] joy);
        logic [7:0] b;
        b = 8'h00;
        for (int i = 4; i <= 6; i++)
            b[i] = !joy[i];
        for (int i = 0; i <= 3; i++)
            b[3 - i] = !joy[i];
        return b;
    endfunction

    function automatic logic [15:0] vstatus_word(input batrider_pkg::video_in_t v);
        logic [15:0] w;
        w = 16'hFFFF;
        if (!v.hsync)
            w[15] = 1'b0;
        if (!v.vsync)
            w[14] = 1'b0;
        if (!v.fblank)
            w[8] = 1'b0;
        w[7:0] = (v.vcount < 9'd256) ? v.vcount[7:0] : 8'hFF;
        return w;
    endfunction

    function automatic logic [22:0] ram_addr(input int bank, input logic [13:0] off);
        logic [23:0] base;
        base = (bank == 0) ? 24'h200000 : 24'h208000;
        return base[23:1] + {9'd0, off};
    endfunction

    // one strobe cycle that returns one cycle after ack with valid low
    task automatic bus_access(input logic rd, input logic [22:0] addr,
                              input logic [1:0] strobe, input logic [15:0] data);
        req.valid <= 1'b1;
        req.read  <= rd;
        req.addr  <= addr;
        req.uds   <= strobe[1];
        req.lds   <= strobe[0];
        req.wdata <= data;
        @(posedge CLK96);
        while (!rsp.ack)
            @(posedge CLK96);
        req.valid <= 1'b0;
        @(posedge CLK96);
    endtask

    task automatic write_ram(input int bank, input logic [13:0] off,
                             input logic [1:0] strobe, input logic [15:0] d);
        if (strobe[1])
            ref_mem[bank][off][15:8] = d[15:8];
        if (strobe[0])
            ref_mem[bank][off][7:0] = d[7:0];
        chk_rdata = 1'b0;
        bus_access(1'b0, ram_addr(bank, off), strobe, d);
    endtask

    task automatic read_ram(input int bank, input logic [13:0] off);
        exp_rdata = ref_mem[bank][off];
        chk_rdata = 1'b1;
        bus_access(1'b1, ram_addr(bank, off), 2'b11, 16'h0000);
    endtask

    task automatic io_read(input logic [23:0] a, input logic [15:0] expected);
        exp_rdata = expected;
        chk_rdata = 1'b1;
        bus_access(1'b1, a[23:1], 2'b11, 16'h0000);
    endtask

    task automatic io_write(input logic [23:0] a, input logic [15:0] d);
        chk_rdata = 1'b0;
        bus_access(1'b0, a[23:1], 2'b11, d);
    endtask

    task automatic gcu_access(input logic rd, input logic [23:0] a,
                              input batrider_pkg::gcu_op_t op, input logic [15:0] d);
        logic [31:0] r;
        r = next_random();
        gcu_delay = 1 + int'(r % 32'd6);
        gcu_acc   = 1'b1;
        exp_op    = op;
        chk_rdata = rd;
        exp_rdata = d;
        if (rd)
            gcu_rdata <= d;
        bus_access(rd, a[23:1], 2'b11, d);
        gcu_acc = 1'b0;
        exp_op  = batrider_pkg::GCU_NONE;
    endtask

    task automatic finish_test(input string name);
        tests_run = tests_run + 1;
        $display("test %0d %s: %0d errors", tests_run, name, error_count - errs_at_start);
        errs_at_start = error_count;
    endtask

    initial begin : stimulus
        batrider_pkg::cab_in_t   new_cab;
        batrider_pkg::video_in_t new_vid;
        logic [63:0]             r64;
        logic [31:0]             r;
        logic [13:0]             off;
        logic [1:0]              lanes;
        RESET96   <= 1'b1;
        req       <= '0;
        cab       <= '0;
        vid       <= '0;
        latch3    <= '0;
        latch4    <= '0;
        gcu_rdata <= '0;
        repeat (16) @(posedge CLK96);
        RESET96 <= 1'b0;
        @(posedge CLK96);

        for (int i = 0; i < RAM_LOOPS; i++) begin
            r   = next_random();
            off = r[13:0];
            write_ram(1, off, 2'b11, r[31:16]);
            r     = next_random();
            lanes = (r[17:16] == 2'b00) ? 2'b10 : r[17:16];  // at least one lane
            write_ram(1, off, lanes, r[15:0]);
            read_ram(1, off);
        end
        finish_test("byte lanes in work RAM");

        for (int i = 0; i < 8; i++) begin
            r   = next_random();
            off = r[13:0];
            write_ram(0, off, 2'b11, r[31:16]);
            write_ram(1, off, 2'b11, ~r[31:16]);
            read_ram(0, off);
            read_ram(1, off);
        end
        finish_test("video and work RAM apart");

        for (int i = 0; i < 4; i++) begin
            r64     = {next_random(), next_random()};
            new_cab = r64[$bits(batrider_pkg::cab_in_t)-1:0];
            cab    <= new_cab;
            io_read(24'h500000, {player_byte(new_cab.joy2), player_byte(new_cab.joy1)});
            io_read(24'h500004, {new_cab.dsw_b, new_cab.dsw_a});
        end
        finish_test("player inputs and DIP");

        for (int i = 0; i < 8; i++) begin
            r       = next_random();
            new_vid = r[11:0];
            vid    <= new_vid;
            io_read(24'h500006, vstatus_word(new_vid));
        end
        finish_test("video status");

        for (int i = 0; i < 4; i++) begin
            r       = next_random();
            exp_snd = r[7:0];
            io_write(24'h500020, r[15:0]);
            exp_snd2 = r[23:16];
            io_write(24'h500022, r[31:16]);
            r       = next_random();
            latch3 <= r[7:0];
            latch4 <= r[15:8];
            io_read(24'h500008, {8'h00, r[7:0]});
            io_read(24'h50000A, {8'h00, r[15:8]});
            io_read(24'h300000 + {8'd0, r[31:16]}, 16'h0000);  // nothing mapped there
        end
        finish_test("sound latches and unmapped");

        r = next_random();
        gcu_access(1'b0, 24'h400000, batrider_pkg::GCU_WRITE_REG, r[15:0]);
        gcu_access(1'b0, 24'h400004, batrider_pkg::GCU_SELECT_REG, r[31:16]);
        gcu_access(1'b0, 24'h400008, batrider_pkg::GCU_WRITE_RAM, ~r[15:0]);
        gcu_access(1'b0, 24'h40000A, batrider_pkg::GCU_WRITE_RAM, ~r[31:16]);
        gcu_access(1'b0, 24'h40000C, batrider_pkg::GCU_SET_RAM_PTR, r[23:8]);
        gcu_access(1'b1, 24'h400008, batrider_pkg::GCU_READ_RAM_H, r[15:0]);
        gcu_access(1'b1, 24'h40000A, batrider_pkg::GCU_READ_RAM_L, r[31:16]);
        for (int s = 0; s < 8; s++) begin
            exp_slot = 3'(s);
            gcu_access(1'b0, 24'h5000C0 + 24'(2 * s), batrider_pkg::GCU_OBJBANK_WR, r[15:0]);
        end
        finish_test("GCU commands and object bank");

        $display("%0d tests run, %0d errors", tests_run, error_count);
        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== batrider_bus.sv ====
// batrider main CPU bus subsystem
`timescale 1ns/10ps

module batrider_bus (
    input  logic                            CLK96,
    input  logic                            RESET96,
    input  batrider_pkg::bus_req_t          req,
    output batrider_pkg::bus_rsp_t          rsp,
    input  batrider_pkg::cab_in_t           cab,
    input  batrider_pkg::video_in_t         vid,
    input  logic [7:0]                      latch3,
    input  logic [7:0]                      latch4,
    input  logic                            gcu_ack,
    input  logic [batrider_pkg::DATA_W-1:0] gcu_rdata,
    output logic [7:0]                      sndlatch,
    output logic [7:0]                      sndlatch2,
    output batrider_pkg::gcu_op_t           gcu_op,
    output logic [2:0]                      objbank_slot
);

    batrider_pkg::dec_t                                               dec;
    logic [batrider_pkg::NUM_RAM_BANKS-1:0][batrider_pkg::DATA_W-1:0] bank_rdata;
    logic [batrider_pkg::DATA_W-1:0]                                  io_rdata;
    logic                                                             gcu_done;

    bus_decoder u_decoder (
        .CLK96   (CLK96),
        .RESET96 (RESET96),
        .req     (req),
        .dec     (dec)
    );

    // video RAM and work RAM
    for (genvar b = 0; b < batrider_pkg::NUM_RAM_BANKS; b++) begin : g_bank
        ram_bank #(.BANK(b)) u_bank (
            .CLK96 (CLK96),
            .dec   (dec),
            .rdata (bank_rdata[b])
        );
    end

    io_ports u_io (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .dec          (dec),
        .cab          (cab),
        .vid          (vid),
        .latch3       (latch3),
        .latch4       (latch4),
        .gcu_ack      (gcu_ack),
        .sndlatch     (sndlatch),
        .sndlatch2    (sndlatch2),
        .gcu_op       (gcu_op),
        .objbank_slot (objbank_slot),
        .io_rdata     (io_rdata),
        .gcu_done     (gcu_done)
    );

    read_return u_return (
        .CLK96      (CLK96),
        .RESET96    (RESET96),
        .dec        (dec),
        .bank_rdata (bank_rdata),
        .io_rdata   (io_rdata),
        .gcu_done   (gcu_done),
        .gcu_rdata  (gcu_rdata),
        .rsp        (rsp)
    );

endmodule

// ==== read_return.sv ====
// read data return and bus ack
`timescale 1ns/10ps

module read_return (
    input  logic                                                   CLK96,
    input  logic                                                   RESET96,
    input  batrider_pkg::dec_t                                     dec,
    input  logic [batrider_pkg::NUM_RAM_BANKS-1:0][batrider_pkg::DATA_W-1:0] bank_rdata,
    input  logic [batrider_pkg::DATA_W-1:0]                        io_rdata,
    input  logic                                                   gcu_done,
    input  logic [batrider_pkg::DATA_W-1:0]                        gcu_rdata,
    output batrider_pkg::bus_rsp_t                                 rsp
);

    logic                            fixed_pend;  // waits one cycle for RAM data
    logic [batrider_pkg::DATA_W-1:0] rdata_sel;

    always_comb begin
        rdata_sel = '0;
        case (dec.region)
            batrider_pkg::REGION_GCU: rdata_sel = gcu_rdata;
            batrider_pkg::REGION_IO:  rdata_sel = io_rdata;
            default: begin
                for (int b = 0; b < batrider_pkg::NUM_RAM_BANKS; b++)
                    if (dec.region == batrider_pkg::bank_region(b))
                        rdata_sel = bank_rdata[b];
            end
        endcase
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            fixed_pend <= 1'b0;
            rsp        <= '0;
        end else begin
            fixed_pend <= dec.first && !dec.gcu_wait;
            rsp.ack    <= fixed_pend || gcu_done;
            if (fixed_pend || gcu_done)
                rsp.rdata <= rdata_sel;  // held until the next access
        end
    end

    // relies on the master dropping valid after each ack
    ack_pulse_a: assert property (@(posedge CLK96) disable iff (RESET96)
        rsp.ack |=> !rsp.ack);

endmodule

// ==== io_ports.sv ====
// I/O ports, sound latches and GCU strobes
`timescale 1ns/10ps

module io_ports (
    input  logic                            CLK96,
    input  logic                            RESET96,
    input  batrider_pkg::dec_t              dec,
    input  batrider_pkg::cab_in_t           cab,
    input  batrider_pkg::video_in_t         vid,
    input  logic [7:0]                      latch3,
    input  logic [7:0]                      latch4,
    input  logic                            gcu_ack,
    output logic [7:0]                      sndlatch,
    output logic [7:0]                      sndlatch2,
    output batrider_pkg::gcu_op_t           gcu_op,
    output logic [2:0]                      objbank_slot,
    output logic [batrider_pkg::DATA_W-1:0] io_rdata,
    output logic                            gcu_done
);

    logic [7:0]            io_off;
    logic [3:0]            gcu_off;
    logic [7:0]            p1_ctrl;
    logic [7:0]            p2_ctrl;
    logic [15:0]           sys_word;
    logic [15:0]           vid_status;
    batrider_pkg::gcu_op_t new_op;
    logic                  io_wr;

    assign io_off  = {dec.req.addr[6:0], 1'b0};
    assign gcu_off = {dec.req.addr[2:0], 1'b0};
    assign io_wr   = dec.first && !dec.req.read && dec.region == batrider_pkg::REGION_IO;

    // cabinet inputs arrive active low
    assign p1_ctrl = {1'b0, ~cab.joy1[6:4],
                      ~cab.joy1[0], ~cab.joy1[1], ~cab.joy1[2], ~cab.joy1[3]};
    assign p2_ctrl = {1'b0, ~cab.joy2[6:4],
                      ~cab.joy2[0], ~cab.joy2[1], ~cab.joy2[2], ~cab.joy2[3]};
    assign sys_word = {cab.dsw_c, 1'b0, ~cab.start[1], ~cab.start[0],
                       ~cab.coin[1], ~cab.coin[0], ~cab.test, 1'b0, ~cab.service};

    // sync bits read back low while active, line count saturates at 0xFF
    assign vid_status = {vid.hsync, vid.vsync, 5'h1F, vid.fblank,
                         vid.vcount[8] ? 8'hFF : vid.vcount[7:0]};

    always_comb begin
        case (io_off)
            batrider_pkg::IO_IN:      io_rdata = {p2_ctrl, p1_ctrl};
            batrider_pkg::IO_SYS_DSW: io_rdata = sys_word;
            batrider_pkg::IO_DSW:     io_rdata = {cab.dsw_b, cab.dsw_a};
            batrider_pkg::IO_VSTATUS: io_rdata = vid_status;
            batrider_pkg::IO_LATCH3:  io_rdata = {8'h00, latch3};
            batrider_pkg::IO_LATCH4:  io_rdata = {8'h00, latch4};
            default:                  io_rdata = '0;
        endcase
    end

    // GCU port offset to command
    always_comb begin
        new_op = batrider_pkg::GCU_NONE;
        if (dec.req.read) begin
            case (gcu_off)
                4'h8:    new_op = batrider_pkg::GCU_READ_RAM_H;
                4'hA:    new_op = batrider_pkg::GCU_READ_RAM_L;
                default: new_op = batrider_pkg::GCU_NONE;
            endcase
        end else begin
            case (gcu_off)
                4'h0:       new_op = batrider_pkg::GCU_WRITE_REG;
                4'h4:       new_op = batrider_pkg::GCU_SELECT_REG;
                4'h8, 4'hA: new_op = batrider_pkg::GCU_WRITE_RAM;
                4'hC:       new_op = batrider_pkg::GCU_SET_RAM_PTR;
                default:    new_op = batrider_pkg::GCU_NONE;
            endcase
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sndlatch     <= 8'h00;
            sndlatch2    <= 8'h00;
            objbank_slot <= 3'd0;
            gcu_op       <= batrider_pkg::GCU_NONE;
            gcu_done     <= 1'b0;
        end else begin
            gcu_done <= 1'b0;
            if (gcu_op != batrider_pkg::GCU_NONE && gcu_ack) begin
                gcu_op   <= batrider_pkg::GCU_NONE;  // handshake done
                gcu_done <= 1'b1;
            end
            if (io_wr && dec.gcu_wait) begin
                objbank_slot <= dec.req.addr[2:0];  // offset bits 3..1
                gcu_op       <= batrider_pkg::GCU_OBJBANK_WR;
            end else if (io_wr && io_off == batrider_pkg::IO_SNDLATCH) begin
                sndlatch <= dec.req.wdata[7:0];
            end else if (io_wr && io_off == batrider_pkg::IO_SNDLATCH2) begin
                sndlatch2 <= dec.req.wdata[7:0];
            end else if (dec.first && dec.region == batrider_pkg::REGION_GCU) begin
                if (new_op == batrider_pkg::GCU_NONE)
                    gcu_done <= 1'b1;  // unused port, finish at once
                else
                    gcu_op <= new_op;
            end
        end
    end

    // master stays held, so a pending command cannot be replaced
    gcu_hold_a: assert property (@(posedge CLK96) disable iff (RESET96)
        (gcu_op != batrider_pkg::GCU_NONE && !gcu_ack) |=> gcu_op == $past(gcu_op));

endmodule

// ==== ram_bank.sv ====
// byte lane RAM region
`timescale 1ns/10ps

module ram_bank #(
    parameter int BANK = 0
) (
    input  logic                            CLK96,
    input  batrider_pkg::dec_t              dec,
    output logic [batrider_pkg::DATA_W-1:0] rdata
);

    localparam int DEPTH = 2 ** batrider_pkg::RAM_AW;

    logic [7:0]                      mem_hi [DEPTH];
    logic [7:0]                      mem_lo [DEPTH];
    logic [batrider_pkg::RAM_AW-1:0] addr;

    // low word address bits, region already picked by the decoder
    assign addr = dec.req.addr[batrider_pkg::RAM_AW-1:0];

    always_ff @(posedge CLK96) begin
        if (dec.we[BANK][1])
            mem_hi[addr] <= dec.req.wdata[15:8];  // UDS lane
        if (dec.we[BANK][0])
            mem_lo[addr] <= dec.req.wdata[7:0];
        rdata <= {mem_hi[addr], mem_lo[addr]};
    end

endmodule

// ==== bus_decoder.sv ====
// main bus address decoder
`timescale 1ns/10ps

module bus_decoder (
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  batrider_pkg::bus_req_t req,
    output batrider_pkg::dec_t     dec
);

    batrider_pkg::bus_req_t                      req_q;
    logic                                        first_q;
    logic [batrider_pkg::ADDR_W:0]               byte_addr;
    batrider_pkg::region_t                       region;
    logic                                        objbank_wr;
    logic [batrider_pkg::NUM_RAM_BANKS-1:0][1:0] we;
    logic [batrider_pkg::NUM_RAM_BANKS-1:0]      bank_we_any;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            req_q   <= '0;
            first_q <= 1'b0;
        end else begin
            req_q   <= req;
            first_q <= req.valid && !req_q.valid;  // rising edge of valid only
        end
    end

    assign byte_addr = {req_q.addr, 1'b0};  // easier to match the memory map

    always_comb begin
        region = batrider_pkg::REGION_NONE;
        if (!req_q.valid)
            region = batrider_pkg::REGION_NONE;
        else if (byte_addr[batrider_pkg::ADDR_W:15] == batrider_pkg::VRAM_BASE[23:15])
            region = batrider_pkg::REGION_VRAM;
        else if (byte_addr[batrider_pkg::ADDR_W:15] == batrider_pkg::WRAM_BASE[23:15])
            region = batrider_pkg::REGION_WRAM;
        else if (byte_addr[batrider_pkg::ADDR_W:4] == batrider_pkg::GCU_BASE[23:4])
            region = batrider_pkg::REGION_GCU;
        else if (byte_addr[batrider_pkg::ADDR_W:8] == batrider_pkg::IO_BASE[23:8])
            region = batrider_pkg::REGION_IO;
    end

    // object bank slot write also goes through the GCU
    assign objbank_wr = (region == batrider_pkg::REGION_IO) && !req_q.read &&
                        (byte_addr[7:4] == batrider_pkg::IO_OBJBANK[7:4]);

    always_comb begin
        for (int b = 0; b < batrider_pkg::NUM_RAM_BANKS; b++) begin
            we[b] = 2'b00;
            if (first_q && !req_q.read && region == batrider_pkg::bank_region(b))
                we[b] = {req_q.uds, req_q.lds};
            bank_we_any[b] = |we[b];
        end
    end

    always_comb begin
        dec.region   = region;
        dec.first    = first_q;
        dec.gcu_wait = (region == batrider_pkg::REGION_GCU) || objbank_wr;
        dec.req      = req_q;
        dec.we       = we;
    end

    // bank regions in the package must never overlap
    bank_we_onehot_a: assert property (@(posedge CLK96) disable iff (RESET96)
        $onehot0(bank_we_any));

endmodule

// ==== batrider_pkg.sv ====
// batrider main bus
// memory map and shared types
package batrider_pkg;

    localparam int ADDR_W        = 23;  // word address, A23 down to A1
    localparam int DATA_W        = 16;
    localparam int RAM_AW        = 14;  // 16k words per RAM region
    localparam int NUM_RAM_BANKS = 2;   // index 0 is video RAM

    // region bases as 24-bit byte addresses
    localparam logic [ADDR_W:0] VRAM_BASE = 24'h200000;  // 32k bytes
    localparam logic [ADDR_W:0] WRAM_BASE = 24'h208000;  // 32k bytes
    localparam logic [ADDR_W:0] GCU_BASE  = 24'h400000;  // 16 bytes of ports
    localparam logic [ADDR_W:0] IO_BASE   = 24'h500000;  // 256 bytes

    // I/O byte offsets inside the 0x500000 page
    localparam logic [7:0] IO_IN        = 8'h00;  // player 1 and 2
    localparam logic [7:0] IO_SYS_DSW   = 8'h02;  // coins, start, DIP C
    localparam logic [7:0] IO_DSW       = 8'h04;  // DIP A and B
    localparam logic [7:0] IO_VSTATUS   = 8'h06;
    localparam logic [7:0] IO_LATCH3    = 8'h08;  // from the sound CPU
    localparam logic [7:0] IO_LATCH4    = 8'h0A;
    localparam logic [7:0] IO_SNDLATCH  = 8'h20;  // to the sound CPU
    localparam logic [7:0] IO_SNDLATCH2 = 8'h22;
    localparam logic [7:0] IO_OBJBANK   = 8'hC0;  // eight slots up to 0xCE

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_VRAM,
        REGION_WRAM,
        REGION_GCU,
        REGION_IO
    } region_t;

    typedef enum logic [2:0] {
        GCU_NONE,
        GCU_WRITE_REG,
        GCU_SELECT_REG,
        GCU_WRITE_RAM,
        GCU_READ_RAM_H,
        GCU_READ_RAM_L,
        GCU_SET_RAM_PTR,
        GCU_OBJBANK_WR
    } gcu_op_t;

    typedef struct packed {
        logic              valid;
        logic              read;   // high for a read cycle
        logic [ADDR_W-1:0] addr;
        logic              uds;    // upper byte lane strobe
        logic              lds;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              ack;    // one cycle pulse
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        region_t                             region;
        logic                                first;     // first cycle of a request
        logic                                gcu_wait;  // ends on the GCU handshake
        bus_req_t                            req;
        logic [NUM_RAM_BANKS-1:0][1:0]       we;        // {upper, lower} per bank
    } dec_t;

    typedef struct packed {
        logic [9:0] joy1;
        logic [9:0] joy2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic       test;
        logic [7:0] dsw_a;
        logic [7:0] dsw_b;
        logic [7:0] dsw_c;
    } cab_in_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       fblank;
        logic [8:0] vcount;
    } video_in_t;

    // which decoded region each RAM bank answers to
    function automatic region_t bank_region(int bank);
        return (bank == 0) ? REGION_VRAM : REGION_WRAM;
    endfunction

endpackage
